/* hdl/decoding_graph_pkg.sv */
package decoding_graph_pkg;

    localparam int grid_width_x = 3;
    localparam int grid_width_z = 2;
    localparam int grid_width_u = 3;

    localparam int x_bit_width = 2;
    localparam int z_bit_width = 1;
    localparam int u_bit_width = 2;
    localparam int address_width = x_bit_width + z_bit_width + u_bit_width;

    localparam int pu_count_per_round = grid_width_x * grid_width_z;
    localparam int pu_count = pu_count_per_round * grid_width_u;

    localparam int neighbor_count = 6;
    localparam int neighbor_idx_north = 0;
    localparam int neighbor_idx_south = 1;
    localparam int neighbor_idx_west = 2;
    localparam int neighbor_idx_east = 3;
    localparam int neighbor_idx_down = 4;
    localparam int neighbor_idx_up = 5;

    localparam int max_weight = 2;  // a link at this weight joins its two ends

    typedef logic [address_width-1:0] address_t;  // u, x, z from high to low bits
    typedef logic [1:0] weight_t;
    typedef logic [pu_count_per_round-1:0] round_t;  // bit x * grid_width_z + z

    typedef enum logic [2:0] {
        stage_idle,
        stage_clear,
        stage_load,
        stage_grow,
        stage_merge
    } stage_t;

    // flat position of a unit in the per-unit output arrays
    function automatic int pu_index(int x, int z, int u);
        return u * pu_count_per_round + x * grid_width_z + z;
    endfunction

    function automatic address_t pu_address(int x, int z, int u);
        address_t addr;
        addr = address_t'((u << (x_bit_width + z_bit_width)) | (x << z_bit_width) | z);
        return addr;
    endfunction

endpackage

/* hdl/neighbor_link.sv */
`timescale 1ns/1ps

module neighbor_link (
    input  logic                          clk,
    input  logic                          rst_n,
    input  decoding_graph_pkg::stage_t    global_stage,
    input  logic                          a_active,
    input  logic                          b_active,
    output logic                          fully_grown
);

    import decoding_graph_pkg::*;

    weight_t    weight;
    logic [1:0] active_count;
    logic [2:0] weight_sum;  // one bit wider so the saturation check sees the carry

    assign active_count = 2'(a_active) + 2'(b_active);
    assign weight_sum = 3'(weight) + 3'(active_count);

    always_ff @(posedge clk) begin
        if (!rst_n || global_stage == stage_clear) begin
            weight <= '0;
        end else if (global_stage == stage_grow) begin
            if (weight_sum >= 3'(max_weight)) begin
                weight <= weight_t'(max_weight);  // clamp instead of wrapping
            end else begin
                weight <= weight_sum[1:0];
            end
        end
    end

    assign fully_grown = (weight == weight_t'(max_weight));

    weight_bounded: assert property (
        @(posedge clk) disable iff (!rst_n)
        weight <= weight_t'(max_weight)
    ) else $error("link weight %0d above max_weight", weight);

endmodule

/* hdl/processing_unit.sv */
`timescale 1ns/1ps

module processing_unit #(
    parameter decoding_graph_pkg::address_t address = '0
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  decoding_graph_pkg::stage_t          global_stage,
    input  logic                                measurement_in,
    output logic                                measurement_out,
    input  logic [decoding_graph_pkg::neighbor_count-1:0] neighbor_fully_grown,
    input  decoding_graph_pkg::address_t        neighbor_root [decoding_graph_pkg::neighbor_count],
    input  logic [decoding_graph_pkg::neighbor_count-1:0] neighbor_active,
    output decoding_graph_pkg::address_t        root,
    output logic                                active,
    output logic                                busy
);

    import decoding_graph_pkg::*;

    address_t merged_root;
    logic     merged_active;
    address_t next_root;
    logic     next_active;
    logic     next_measurement;

    // smallest root and combined active flag over this unit and its joined neighbours
    always_comb begin
        merged_root = root;
        merged_active = active;
        for (int n = 0; n < neighbor_count; n++) begin
            if (neighbor_fully_grown[n]) begin
                if (neighbor_root[n] < merged_root) begin
                    merged_root = neighbor_root[n];
                end
                merged_active = merged_active | neighbor_active[n];
            end
        end
    end

    always_comb begin
        next_root = root;
        next_active = active;
        next_measurement = measurement_out;
        case (global_stage)
            stage_load: begin
                next_measurement = measurement_in;  // the old value moves one layer down
                next_active = measurement_in;
                next_root = address;
            end
            stage_merge: begin
                next_root = merged_root;
                next_active = merged_active;
            end
            default: begin
                next_root = root;  // idle and grow leave the vertex alone
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || global_stage == stage_clear) begin
            measurement_out <= 1'b0;
            root <= address;
            active <= 1'b0;
            busy <= 1'b0;
        end else begin
            measurement_out <= next_measurement;
            root <= next_root;
            active <= next_active;
            busy <= (next_root != root) || (next_active != active);  // still settling
        end
    end

    // roots only ever move towards the cluster minimum
    root_never_rises: assert property (
        @(posedge clk) disable iff (!rst_n)
        global_stage == stage_merge |=> root <= $past(root)
    ) else $error("unit %0d root rose from %0d to %0d during merge",
                  address, $past(root), root);

endmodule

/* hdl/decoding_graph.sv */
`timescale 1ns/1ps

module decoding_graph (
    input  logic                                clk,
    input  logic                                rst_n,
    input  decoding_graph_pkg::round_t          measurements,
    input  decoding_graph_pkg::stage_t          global_stage,
    output decoding_graph_pkg::address_t        roots [decoding_graph_pkg::pu_count],
    output logic [decoding_graph_pkg::pu_count-1:0] active,
    output logic [decoding_graph_pkg::pu_count-1:0] busy
);

    import decoding_graph_pkg::*;

    logic [pu_count-1:0] measurement_chain;  // each unit's stored measurement

    // link outputs, indexed by the lower end of each link
    logic ns_grown [grid_width_u][grid_width_x-1][grid_width_z];
    logic ew_grown [grid_width_u][grid_width_x][grid_width_z-1];
    logic ud_grown [grid_width_u-1][grid_width_x][grid_width_z];

    for (genvar gu = grid_width_u - 1; gu >= 0; gu--) begin : pu_u
        for (genvar gx = 0; gx < grid_width_x; gx++) begin : pu_x
            for (genvar gz = 0; gz < grid_width_z; gz++) begin : pu_z
                logic                      local_measurement;
                logic [neighbor_count-1:0] nb_grown;
                address_t                  nb_root [neighbor_count];
                logic [neighbor_count-1:0] nb_active;

                if (gu == grid_width_u - 1) begin : top_layer
                    assign local_measurement = measurements[gx * grid_width_z + gz];
                end else begin : inner_layer
                    assign local_measurement = measurement_chain[pu_index(gx, gz, gu + 1)];
                end

                if (gx > 0) begin : north
                    assign nb_grown[neighbor_idx_north] = ns_grown[gu][gx-1][gz];
                    assign nb_root[neighbor_idx_north] = roots[pu_index(gx - 1, gz, gu)];
                    assign nb_active[neighbor_idx_north] = active[pu_index(gx - 1, gz, gu)];
                end else begin : north_edge
                    assign nb_grown[neighbor_idx_north] = 1'b0;
                    assign nb_root[neighbor_idx_north] = pu_address(gx, gz, gu);
                    assign nb_active[neighbor_idx_north] = 1'b0;
                end

                if (gx < grid_width_x - 1) begin : south
                    assign nb_grown[neighbor_idx_south] = ns_grown[gu][gx][gz];
                    assign nb_root[neighbor_idx_south] = roots[pu_index(gx + 1, gz, gu)];
                    assign nb_active[neighbor_idx_south] = active[pu_index(gx + 1, gz, gu)];
                end else begin : south_edge
                    assign nb_grown[neighbor_idx_south] = 1'b0;
                    assign nb_root[neighbor_idx_south] = pu_address(gx, gz, gu);
                    assign nb_active[neighbor_idx_south] = 1'b0;
                end

                if (gz > 0) begin : west
                    assign nb_grown[neighbor_idx_west] = ew_grown[gu][gx][gz-1];
                    assign nb_root[neighbor_idx_west] = roots[pu_index(gx, gz - 1, gu)];
                    assign nb_active[neighbor_idx_west] = active[pu_index(gx, gz - 1, gu)];
                end else begin : west_edge
                    assign nb_grown[neighbor_idx_west] = 1'b0;
                    assign nb_root[neighbor_idx_west] = pu_address(gx, gz, gu);
                    assign nb_active[neighbor_idx_west] = 1'b0;
                end

                if (gz < grid_width_z - 1) begin : east
                    assign nb_grown[neighbor_idx_east] = ew_grown[gu][gx][gz];
                    assign nb_root[neighbor_idx_east] = roots[pu_index(gx, gz + 1, gu)];
                    assign nb_active[neighbor_idx_east] = active[pu_index(gx, gz + 1, gu)];
                end else begin : east_edge
                    assign nb_grown[neighbor_idx_east] = 1'b0;
                    assign nb_root[neighbor_idx_east] = pu_address(gx, gz, gu);
                    assign nb_active[neighbor_idx_east] = 1'b0;
                end

                if (gu > 0) begin : down
                    assign nb_grown[neighbor_idx_down] = ud_grown[gu-1][gx][gz];
                    assign nb_root[neighbor_idx_down] = roots[pu_index(gx, gz, gu - 1)];
                    assign nb_active[neighbor_idx_down] = active[pu_index(gx, gz, gu - 1)];
                end else begin : down_edge
                    assign nb_grown[neighbor_idx_down] = 1'b0;
                    assign nb_root[neighbor_idx_down] = pu_address(gx, gz, gu);
                    assign nb_active[neighbor_idx_down] = 1'b0;
                end

                if (gu < grid_width_u - 1) begin : up
                    assign nb_grown[neighbor_idx_up] = ud_grown[gu][gx][gz];
                    assign nb_root[neighbor_idx_up] = roots[pu_index(gx, gz, gu + 1)];
                    assign nb_active[neighbor_idx_up] = active[pu_index(gx, gz, gu + 1)];
                end else begin : up_edge
                    assign nb_grown[neighbor_idx_up] = 1'b0;
                    assign nb_root[neighbor_idx_up] = pu_address(gx, gz, gu);
                    assign nb_active[neighbor_idx_up] = 1'b0;
                end

                processing_unit #(
                    .address(pu_address(gx, gz, gu))
                ) pu (
                    .clk                  (clk),
                    .rst_n                (rst_n),
                    .global_stage         (global_stage),
                    .measurement_in       (local_measurement),
                    .measurement_out      (measurement_chain[pu_index(gx, gz, gu)]),
                    .neighbor_fully_grown (nb_grown),
                    .neighbor_root        (nb_root),
                    .neighbor_active      (nb_active),
                    .root                 (roots[pu_index(gx, gz, gu)]),
                    .active               (active[pu_index(gx, gz, gu)]),
                    .busy                 (busy[pu_index(gx, gz, gu)])
                );
            end
        end
    end

    // north-south links join x and x + 1
    for (genvar gu = 0; gu < grid_width_u; gu++) begin : ns_u
        for (genvar gx = 0; gx < grid_width_x - 1; gx++) begin : ns_x
            for (genvar gz = 0; gz < grid_width_z; gz++) begin : ns_z
                neighbor_link ns_link (
                    .clk          (clk),
                    .rst_n        (rst_n),
                    .global_stage (global_stage),
                    .a_active     (active[pu_index(gx, gz, gu)]),
                    .b_active     (active[pu_index(gx + 1, gz, gu)]),
                    .fully_grown  (ns_grown[gu][gx][gz])
                );
            end
        end
    end

    for (genvar gu = 0; gu < grid_width_u; gu++) begin : ew_u
        for (genvar gx = 0; gx < grid_width_x; gx++) begin : ew_x
            for (genvar gz = 0; gz < grid_width_z - 1; gz++) begin : ew_z
                neighbor_link ew_link (
                    .clk          (clk),
                    .rst_n        (rst_n),
                    .global_stage (global_stage),
                    .a_active     (active[pu_index(gx, gz, gu)]),
                    .b_active     (active[pu_index(gx, gz + 1, gu)]),
                    .fully_grown  (ew_grown[gu][gx][gz])
                );
            end
        end
    end

    // up-down links join a unit with the same site one round later
    for (genvar gu = 0; gu < grid_width_u - 1; gu++) begin : ud_u
        for (genvar gx = 0; gx < grid_width_x; gx++) begin : ud_x
            for (genvar gz = 0; gz < grid_width_z; gz++) begin : ud_z
                neighbor_link ud_link (
                    .clk          (clk),
                    .rst_n        (rst_n),
                    .global_stage (global_stage),
                    .a_active     (active[pu_index(gx, gz, gu)]),
                    .b_active     (active[pu_index(gx, gz, gu + 1)]),
                    .fully_grown  (ud_grown[gu][gx][gz])
                );
            end
        end
    end

endmodule

/* verification/graph_model.svh */
`ifndef GRAPH_MODEL_SVH
`define GRAPH_MODEL_SVH

logic     model_meas [pu_count];
logic     model_active [pu_count];
int       model_weight [pu_count][3];  // toward south, east and up from the lower end
address_t exp_root [pu_count];
logic     exp_active [pu_count];

function automatic int flat_index(int x, int z, int u);
    return u * grid_width_x * grid_width_z + x * grid_width_z + z;
endfunction

function automatic address_t unit_address(int i);
    int u;
    int x;
    int z;
    u = i / pu_count_per_round;
    x = (i % pu_count_per_round) / grid_width_z;
    z = i % grid_width_z;
    return address_t'((u << (x_bit_width + z_bit_width)) | (x << z_bit_width) | z);
endfunction

// index of the unit at the other end of a link, or -1 at the grid edge
function automatic int far_end(int i, int dir);
    int u;
    int x;
    int z;
    u = i / pu_count_per_round;
    x = (i % pu_count_per_round) / grid_width_z;
    z = i % grid_width_z;
    case (dir)
        0: return (x + 1 < grid_width_x) ? flat_index(x + 1, z, u) : -1;
        1: return (z + 1 < grid_width_z) ? flat_index(x, z + 1, u) : -1;
        default: return (u + 1 < grid_width_u) ? flat_index(x, z, u + 1) : -1;
    endcase
endfunction

task automatic model_clear();
    for (int i = 0; i < pu_count; i++) begin
        model_meas[i] = 1'b0;
        model_active[i] = 1'b0;
        for (int d = 0; d < 3; d++) begin
            model_weight[i][d] = 0;
        end
    end
endtask

task automatic model_load(round_t r);
    for (int i = 0; i < pu_count - pu_count_per_round; i++) begin
        model_meas[i] = model_meas[i + pu_count_per_round];  // lower layer takes the one above
    end
    for (int s = 0; s < pu_count_per_round; s++) begin
        model_meas[pu_count - pu_count_per_round + s] = r[s];
    end
    for (int i = 0; i < pu_count; i++) begin
        model_active[i] = model_meas[i];
    end
endtask

task automatic model_grow();
    int j;
    int sum;
    for (int i = 0; i < pu_count; i++) begin
        for (int d = 0; d < 3; d++) begin
            j = far_end(i, d);
            if (j >= 0) begin
                sum = model_weight[i][d] + int'(model_active[i]) + int'(model_active[j]);
                model_weight[i][d] = (sum > max_weight) ? max_weight : sum;
            end
        end
    end
endtask

// relax labels over fully grown links until every component shares its minimum
task automatic model_components();
    int j;
    for (int i = 0; i < pu_count; i++) begin
        exp_root[i] = unit_address(i);
        exp_active[i] = model_active[i];
    end
    repeat (pu_count) begin
        for (int i = 0; i < pu_count; i++) begin
            for (int d = 0; d < 3; d++) begin
                j = far_end(i, d);
                if (j >= 0 && model_weight[i][d] == max_weight) begin
                    if (exp_root[j] < exp_root[i]) begin
                        exp_root[i] = exp_root[j];
                    end else begin
                        exp_root[j] = exp_root[i];
                    end
                    exp_active[i] = exp_active[i] | exp_active[j];
                    exp_active[j] = exp_active[i];
                end
            end
        end
    end
endtask

task automatic model_step(stage_t s, round_t r);
    case (s)
        stage_clear: model_clear();
        stage_load: model_load(r);
        stage_grow: model_grow();
        stage_merge: begin
            model_components();
            for (int i = 0; i < pu_count; i++) begin
                model_active[i] = exp_active[i];  // merging settles to the component OR
            end
        end
        default: begin
        end
    endcase
endtask

`endif

/* verification/decoding_graph_tb.sv */
`timescale 1ns/1ps

module decoding_graph_tb;

    import decoding_graph_pkg::*;

    logic                clk;
    logic                rst_n;
    round_t              measurements;
    stage_t              global_stage;
    address_t            roots [pu_count];
    logic [pu_count-1:0] active;
    logic [pu_count-1:0] busy;

    int check_count;
    int error_count;
    int timeout_count;

    `include "graph_model.svh"

    decoding_graph dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .measurements (measurements),
        .global_stage (global_stage),
        .roots        (roots),
        .active       (active),
        .busy         (busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // drive one stage for one cycle and return 1 ns after the edge that took it
    task automatic apply_stage(stage_t s, round_t r);
        global_stage = s;
        measurements = r;
        model_step(s, r);
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(string test_name, int expected, int actual);
        check_count++;
        assert (expected == actual) else begin
            error_count++;
            $display("ERROR %s expected=%0d actual=%0d", test_name, expected, actual);
        end
    endtask

    task automatic load_rounds(round_t r0, round_t r1, round_t r2);
        apply_stage(stage_load, r0);
        apply_stage(stage_load, r1);
        apply_stage(stage_load, r2);
    endtask

    task automatic check_quiet(string test_name);
        for (int i = 0; i < pu_count; i++) begin
            check_value(test_name, int'(unit_address(i)), int'(roots[i]));
            check_value(test_name, 0, int'(active[i]));
            check_value(test_name, 0, int'(busy[i]));
        end
    endtask

    task automatic check_grid(string test_name);
        model_components();
        for (int i = 0; i < pu_count; i++) begin
            check_value(test_name, int'(exp_root[i]), int'(roots[i]));
            check_value(test_name, int'(exp_active[i]), int'(active[i]));
        end
    endtask

    task automatic merge_until_settled(string test_name);
        int cycles;
        cycles = 0;
        apply_stage(stage_merge, '0);
        while (busy != '0 && cycles < 100) begin
            apply_stage(stage_merge, '0);
            cycles++;
        end
        if (busy != '0) begin
            timeout_count++;
            $display("%s: busy did not fall within 100 merge cycles", test_name);
        end
        apply_stage(stage_idle, '0);
    endtask

    initial begin
        round_t load_round [3];

        rst_n = 1'b0;
        measurements = '0;
        global_stage = stage_idle;
        check_count = 0;
        error_count = 0;
        timeout_count = 0;
        void'($urandom(81345));
        model_clear();
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // reset and clear leave the grid quiet
        check_quiet("reset");
        load_rounds('1, '1, '1);
        apply_stage(stage_grow, '0);
        apply_stage(stage_merge, '0);
        apply_stage(stage_clear, '0);
        check_quiet("clear");

        // three loads fill the layers from the bottom up
        for (int k = 0; k < grid_width_u; k++) begin
            load_round[k] = round_t'($urandom);
        end
        load_rounds(load_round[0], load_round[1], load_round[2]);
        for (int k = 0; k < grid_width_u; k++) begin
            check_value("load_layers", int'(load_round[k]),
                        int'(active[k * pu_count_per_round +: pu_count_per_round]));
        end

        // two east-west neighbours in layer 0 and a lone defect at the top corner
        apply_stage(stage_clear, '0);
        load_rounds(6'b000011, 6'b000000, 6'b100000);
        apply_stage(stage_grow, '0);
        check_value("pair_link_grown", 1, int'(dut.ew_u[0].ew_x[0].ew_z[0].ew_link.fully_grown));
        check_value("pair_busy_after_grow", 0, int'(busy != '0));
        merge_until_settled("pair_merge");
        check_value("pair_root_low", 0, int'(roots[flat_index(0, 0, 0)]));
        check_value("pair_root_high", 0, int'(roots[flat_index(0, 1, 0)]));
        check_value("isolated_root", int'(unit_address(flat_index(2, 1, 2))),
                    int'(roots[flat_index(2, 1, 2)]));
        check_value("isolated_active", 1, int'(active[flat_index(2, 1, 2)]));
        check_grid("pair_grid");

        // random syndromes grown twice and merged to a fixed point
        repeat (10) begin
            apply_stage(stage_clear, '0);
            load_rounds(round_t'($urandom), round_t'($urandom), round_t'($urandom));
            apply_stage(stage_grow, '0);
            apply_stage(stage_grow, '0);
            merge_until_settled("random_merge");
            check_grid("random_grid");
        end

        // no grown link means a merge moves nothing
        apply_stage(stage_clear, '0);
        load_rounds(round_t'($urandom), round_t'($urandom), round_t'($urandom));
        apply_stage(stage_idle, '0);
        apply_stage(stage_merge, '0);
        for (int i = 0; i < pu_count; i++) begin
            check_value("no_growth_root", int'(unit_address(i)), int'(roots[i]));
            check_value("no_growth_busy", 0, int'(busy[i]));
        end
        check_grid("no_growth_grid");
        apply_stage(stage_idle, '0);

        $display("checks=%0d errors=%0d timeouts=%0d", check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* decoding_graph.f */
+incdir+verification
hdl/decoding_graph_pkg.sv
hdl/neighbor_link.sv
hdl/processing_unit.sv
hdl/decoding_graph.sv
verification/decoding_graph_tb.sv
